// ==== common/mcast_consts.svh ====
// Port counts, widths, address map and FIFO depth for the multicast crossbar, include where needed
`ifndef MCAST_CONSTS_SVH
`define MCAST_CONSTS_SVH

// Requester and target port counts
`define MCAST_NUM_REQ 2
`define MCAST_NUM_TGT 4

// Request payload widths
`define MCAST_ADDR_W 32
`define MCAST_DATA_W 32

// Each target owns a 4 KiB region, index sits right above the region offset
`define MCAST_IDX_LSB 12
`define MCAST_IDX_W 2

// Decoded requests buffered between ingress and fanout, keep a power of two
`define MCAST_FIFO_DEPTH 4

`endif

// ==== common/mcast_types_pkg.sv ====
// Data path types of the multicast crossbar, referenced by scoped name from RTL and testbench
`include "mcast_consts.svh"

package mcast_types_pkg;

  typedef logic [`MCAST_ADDR_W-1:0] addr_t;
  typedef logic [`MCAST_DATA_W-1:0] data_t;

  // One bit per target that still has to see the request
  typedef logic [`MCAST_NUM_TGT-1:0] tgt_mask_t;

  typedef logic [$clog2(`MCAST_NUM_REQ)-1:0] req_idx_t;

  // Decoded request as it travels from ingress through the FIFO to fanout
  typedef struct packed {
    addr_t     addr;
    data_t     data;
    tgt_mask_t dest;
    req_idx_t  req_idx;
    logic      dec_err;
  } req_entry_t;

endpackage

// ==== common/mcast_ctrl_pkg.sv ====
// Control encodings of the multicast crossbar: response codes and fanout FSM states
package mcast_ctrl_pkg;

  typedef enum logic {
    RESP_OKAY   = 1'b0,
    RESP_DECERR = 1'b1
  } resp_e;

  // Idle waits for a FIFO head, issue drives the pending targets
  typedef enum logic {
    FAN_IDLE  = 1'b0,
    FAN_ISSUE = 1'b1
  } fan_state_e;

endpackage

// ==== common/mcast_req_if.sv ====
// Valid/ready link for one decoded request, used between ingress, FIFO and fanout
`timescale 1ns/1ns

interface mcast_req_if;

  logic                        valid;
  logic                        ready;
  // Held steady from valid rising until the transfer
  mcast_types_pkg::req_entry_t entry;

  modport sender (
    output valid,
    output entry,
    input  ready
  );

  modport receiver (
    input  valid,
    input  entry,
    output ready
  );

endinterface

// ==== ingress/mcast_ingress.sv ====
// Crossbar ingress, picks one requester round-robin and decodes its multicast destination set
`timescale 1ns/1ns
`include "mcast_consts.svh"

module mcast_ingress (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                   [`MCAST_NUM_REQ-1:0]   req_valid_i,
  output logic                   [`MCAST_NUM_REQ-1:0]   req_ready_o,
  input  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0]   req_addr_i,
  input  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0]   req_mask_i,
  input  mcast_types_pkg::data_t [`MCAST_NUM_REQ-1:0]   req_data_i,
  mcast_req_if.sender                                   out_if
);

  localparam int IDX_W  = `MCAST_IDX_W;
  localparam int IDX_HI = `MCAST_IDX_LSB + `MCAST_IDX_W - 1;

  mcast_types_pkg::req_idx_t  rr_q;
  mcast_types_pkg::req_idx_t  gnt_idx;
  logic [`MCAST_NUM_REQ-1:0]  grant;
  mcast_types_pkg::addr_t     sel_addr;
  logic [IDX_W-1:0]           addr_idx;
  logic [IDX_W-1:0]           mask_idx;
  logic                       dec_err;
  mcast_types_pkg::tgt_mask_t dest;

  // Search starts at the round-robin pointer, first valid requester wins
  always_comb begin
    mcast_types_pkg::req_idx_t cand;
    logic                      found;
    grant   = '0;
    gnt_idx = rr_q;
    found   = 1'b0;
    for (int k = 0; k < `MCAST_NUM_REQ; k++) begin
      cand = mcast_types_pkg::req_idx_t'(int'(rr_q) + k);
      if (!found && req_valid_i[cand]) begin
        found       = 1'b1;
        gnt_idx     = cand;
        grant[cand] = 1'b1;
      end
    end
  end

  assign sel_addr = req_addr_i[gnt_idx];
  assign addr_idx = sel_addr[IDX_HI:`MCAST_IDX_LSB];
  assign mask_idx = req_mask_i[gnt_idx][IDX_HI:`MCAST_IDX_LSB];

  // Anything above the last region is unmapped
  assign dec_err = |sel_addr[`MCAST_ADDR_W-1:IDX_HI+1];

  // Masked index bits match either value, unmasked ones must agree with the address
  always_comb begin
    for (int j = 0; j < `MCAST_NUM_TGT; j++) begin
      dest[j] = !dec_err && (((addr_idx ^ IDX_W'(j)) & ~mask_idx) == '0);
    end
  end

  assign out_if.valid = |req_valid_i;
  assign out_if.entry = '{addr: sel_addr, data: req_data_i[gnt_idx], dest: dest,
                          req_idx: gnt_idx, dec_err: dec_err};
  assign req_ready_o  = grant & {`MCAST_NUM_REQ{out_if.ready}};

  // A stalled winner keeps top priority so the offered entry stays put
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= '0;
    end else if (out_if.valid && out_if.ready) begin
      rr_q <= gnt_idx + 1'b1;
    end else if (out_if.valid) begin
      rr_q <= gnt_idx;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grant) && ((grant & ~req_valid_i) == '0));

endmodule

// ==== design/mcast_req_fifo.sv ====
// Circular buffer of decoded requests between crossbar ingress and fanout
`timescale 1ns/1ns
`include "mcast_consts.svh"

module mcast_req_fifo (
  input  logic           clk_i,
  input  logic           arst_n_i,
  mcast_req_if.receiver  in_if,
  mcast_req_if.sender    out_if
);

  localparam int DEPTH = `MCAST_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  mcast_types_pkg::req_entry_t mem_q [DEPTH];
  logic [PTR_W-1:0]            wr_ptr_q;
  logic [PTR_W-1:0]            rd_ptr_q;
  logic [CNT_W-1:0]            count_q;
  logic                        full;
  logic                        wr_en;
  logic                        rd_en;

  assign full         = (count_q == CNT_W'(DEPTH));
  assign in_if.ready  = !full;
  assign out_if.valid = (count_q != '0);
  assign out_if.entry = mem_q[rd_ptr_q];

  assign wr_en = in_if.valid && in_if.ready;
  assign rd_en = out_if.valid && out_if.ready;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= in_if.entry;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // A write never lands on a slot that still holds an unread entry
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_en |-> (wr_ptr_q != rd_ptr_q) || (count_q == '0));

endmodule

// ==== fanout/mcast_fanout.sv ====
// Crossbar fanout, drives each request to all its targets and pulses the requester response
`timescale 1ns/1ns
`include "mcast_consts.svh"

module mcast_fanout (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  mcast_req_if.receiver                                 in_if,
  output logic                   [`MCAST_NUM_TGT-1:0]   tgt_valid_o,
  input  logic                   [`MCAST_NUM_TGT-1:0]   tgt_ready_i,
  output mcast_types_pkg::addr_t [`MCAST_NUM_TGT-1:0]   tgt_addr_o,
  output mcast_types_pkg::data_t [`MCAST_NUM_TGT-1:0]   tgt_data_o,
  output logic                   [`MCAST_NUM_REQ-1:0]   req_resp_valid_o,
  output logic                   [`MCAST_NUM_REQ-1:0]   req_resp_err_o
);

  mcast_ctrl_pkg::fan_state_e  state_q;
  mcast_types_pkg::req_entry_t cur_q;
  mcast_types_pkg::tgt_mask_t  pend_q;
  mcast_ctrl_pkg::resp_e       resp;
  logic                        issuing;
  logic                        done;
  logic                        take;

  assign issuing     = (state_q == mcast_ctrl_pkg::FAN_ISSUE);
  assign tgt_valid_o = issuing ? pend_q : '0;

  // Entry commits once the last pending targets handshake, a decode error has none
  assign done        = issuing && ((pend_q & ~tgt_ready_i) == '0);
  assign in_if.ready = !issuing || done;
  assign take        = in_if.valid && in_if.ready;

  assign resp = cur_q.dec_err ? mcast_ctrl_pkg::RESP_DECERR : mcast_ctrl_pkg::RESP_OKAY;

  always_comb begin
    for (int i = 0; i < `MCAST_NUM_REQ; i++) begin
      req_resp_valid_o[i] = done && (cur_q.req_idx == mcast_types_pkg::req_idx_t'(i));
      req_resp_err_o[i]   = req_resp_valid_o[i] && (resp == mcast_ctrl_pkg::RESP_DECERR);
    end
  end

  // Same payload on every target, valid selects who takes it
  always_comb begin
    for (int j = 0; j < `MCAST_NUM_TGT; j++) begin
      tgt_addr_o[j] = cur_q.addr;
      tgt_data_o[j] = cur_q.data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= mcast_ctrl_pkg::FAN_IDLE;
      pend_q  <= '0;
    end else if (take) begin
      state_q <= mcast_ctrl_pkg::FAN_ISSUE;
      pend_q  <= in_if.entry.dest;
    end else if (done) begin
      state_q <= mcast_ctrl_pkg::FAN_IDLE;
      pend_q  <= '0;
    end else if (issuing) begin
      pend_q <= pend_q & ~tgt_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      cur_q <= in_if.entry;
    end
  end

  // Offered beat stays up and unchanged until the target takes it
  for (genvar j = 0; j < `MCAST_NUM_TGT; j++) begin : gen_tgt_hold
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_valid_o[j] && !tgt_ready_i[j] |=> tgt_valid_o[j] && $stable(tgt_data_o[j]));
  end

endmodule

// ==== design/mcast_xbar_top.sv ====
// Multicast write crossbar top, chains ingress, request FIFO and fanout behind plain ports
`timescale 1ns/1ns
`include "mcast_consts.svh"

module mcast_xbar_top (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                   [`MCAST_NUM_REQ-1:0]   req_valid_i,
  output logic                   [`MCAST_NUM_REQ-1:0]   req_ready_o,
  input  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0]   req_addr_i,
  input  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0]   req_mask_i,
  input  mcast_types_pkg::data_t [`MCAST_NUM_REQ-1:0]   req_data_i,
  output logic                   [`MCAST_NUM_REQ-1:0]   req_resp_valid_o,
  output logic                   [`MCAST_NUM_REQ-1:0]   req_resp_err_o,
  output logic                   [`MCAST_NUM_TGT-1:0]   tgt_valid_o,
  input  logic                   [`MCAST_NUM_TGT-1:0]   tgt_ready_i,
  output mcast_types_pkg::addr_t [`MCAST_NUM_TGT-1:0]   tgt_addr_o,
  output mcast_types_pkg::data_t [`MCAST_NUM_TGT-1:0]   tgt_data_o
);

  mcast_req_if ing_if ();
  mcast_req_if fan_if ();

  mcast_ingress i_ingress (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_addr_i  ( req_addr_i  ),
    .req_mask_i  ( req_mask_i  ),
    .req_data_i  ( req_data_i  ),
    .out_if      ( ing_if      )
  );

  mcast_req_fifo i_req_fifo (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .in_if    ( ing_if   ),
    .out_if   ( fan_if   )
  );

  mcast_fanout i_fanout (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .in_if            ( fan_if           ),
    .tgt_valid_o      ( tgt_valid_o      ),
    .tgt_ready_i      ( tgt_ready_i      ),
    .tgt_addr_o       ( tgt_addr_o       ),
    .tgt_data_o       ( tgt_data_o       ),
    .req_resp_valid_o ( req_resp_valid_o ),
    .req_resp_err_o   ( req_resp_err_o   )
  );

endmodule

// ==== verif/mcast_checker.sv ====
// Crossbar checker, predicts target traffic and responses from accepted requests and compares
`timescale 1ns/1ns
`include "mcast_consts.svh"

module mcast_checker (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                   [`MCAST_NUM_REQ-1:0]   req_valid_i,
  input  logic                   [`MCAST_NUM_REQ-1:0]   req_ready_i,
  input  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0]   req_addr_i,
  input  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0]   req_mask_i,
  input  mcast_types_pkg::data_t [`MCAST_NUM_REQ-1:0]   req_data_i,
  input  logic                   [`MCAST_NUM_REQ-1:0]   resp_valid_i,
  input  logic                   [`MCAST_NUM_REQ-1:0]   resp_err_i,
  input  logic                   [`MCAST_NUM_TGT-1:0]   tgt_valid_i,
  input  logic                   [`MCAST_NUM_TGT-1:0]   tgt_ready_i,
  input  mcast_types_pkg::addr_t [`MCAST_NUM_TGT-1:0]   tgt_addr_i,
  input  mcast_types_pkg::data_t [`MCAST_NUM_TGT-1:0]   tgt_data_i,
  output int                                            data_errs_o,
  output int                                            resp_errs_o,
  output int                                            proto_errs_o,
  output int                                            pending_o,
  output int                                            stalls_o
);

  // Expected beats per target in arrival order, expected response codes per requester
  mcast_types_pkg::data_t exp_data [`MCAST_NUM_TGT][$];
  mcast_types_pkg::addr_t exp_addr [`MCAST_NUM_TGT][$];
  logic                   exp_err  [`MCAST_NUM_REQ][$];
  int                     settle;

  initial begin
    data_errs_o  = 0;
    resp_errs_o  = 0;
    proto_errs_o = 0;
    pending_o    = 0;
    stalls_o     = 0;
    settle       = 0;
  end

  // Target j gets the beat when every unmasked index bit equals the address bit
  task automatic predict(input mcast_types_pkg::addr_t addr, input mcast_types_pkg::addr_t mask,
                         input mcast_types_pkg::data_t data, input int r);
    logic hit;
    if (addr[`MCAST_ADDR_W-1:`MCAST_IDX_LSB+`MCAST_IDX_W] != '0) begin
      exp_err[r].push_back(1'b1);
    end else begin
      for (int j = 0; j < `MCAST_NUM_TGT; j++) begin
        hit = 1'b1;
        for (int b = 0; b < `MCAST_IDX_W; b++) begin
          if (!mask[`MCAST_IDX_LSB+b] && (addr[`MCAST_IDX_LSB+b] != j[b])) begin
            hit = 1'b0;
          end
        end
        if (hit) begin
          exp_data[j].push_back(data);
          exp_addr[j].push_back(addr);
        end
      end
      exp_err[r].push_back(1'b0);
    end
  endtask

  // Inputs change on the falling edge, so sample midway to the rising edge
  always begin
    int cnt;
    @(negedge clk_i);
    #2;
    if (!arst_n_i) begin
      settle = 0;
    end else if (settle < 3) begin
      settle++;
    end
    if (settle < 3 && (tgt_valid_i != '0 || req_ready_i != '0 || resp_valid_i != '0)) begin
      $display("Error: after reset tgt_valid_o=%h req_ready_o=%h req_resp_valid_o=%h",
               tgt_valid_i, req_ready_i, resp_valid_i);
      proto_errs_o++;
    end
    for (int r = 0; r < `MCAST_NUM_REQ; r++) begin
      if (req_valid_i[r] && req_ready_i[r]) begin
        predict(req_addr_i[r], req_mask_i[r], req_data_i[r], r);
      end
    end
    // Nobody is taken while someone offers only when the FIFO is full
    if (req_valid_i != '0 && req_ready_i == '0) begin
      stalls_o++;
    end
    for (int j = 0; j < `MCAST_NUM_TGT; j++) begin
      if (tgt_valid_i[j] && tgt_ready_i[j]) begin
        if (exp_data[j].size() == 0) begin
          $display("Error: tgt_data_o[%0d]=%h arrived but nothing was predicted", j,
                   tgt_data_i[j]);
          data_errs_o++;
        end else begin
          if (tgt_data_i[j] != exp_data[j][0] || tgt_addr_i[j] != exp_addr[j][0]) begin
            $display("Error: tgt_data_o[%0d]=%h tgt_addr_o=%h, expected %h at %h", j,
                     tgt_data_i[j], tgt_addr_i[j], exp_data[j][0], exp_addr[j][0]);
            data_errs_o++;
          end
          void'(exp_data[j].pop_front());
          void'(exp_addr[j].pop_front());
        end
      end
    end
    for (int r = 0; r < `MCAST_NUM_REQ; r++) begin
      if (resp_valid_i[r]) begin
        if (exp_err[r].size() == 0) begin
          $display("Requester %0d got a response for a request it never made", r);
          resp_errs_o++;
        end else begin
          if (resp_err_i[r] != exp_err[r][0]) begin
            $display("Error: req_resp_err_o[%0d]=%h, expected %h", r, resp_err_i[r],
                     exp_err[r][0]);
            resp_errs_o++;
          end
          void'(exp_err[r].pop_front());
        end
      end
    end
    cnt = 0;
    for (int j = 0; j < `MCAST_NUM_TGT; j++) begin
      cnt += exp_data[j].size();
    end
    for (int r = 0; r < `MCAST_NUM_REQ; r++) begin
      cnt += exp_err[r].size();
    end
    pending_o = cnt;
  end

endmodule

// ==== verif/tb_mcast_xbar.sv ====
// Testbench top for the multicast crossbar, drives requests from the tests file and checks them
`timescale 1ns/1ns
`include "mcast_consts.svh"

module tb_mcast_xbar;

  localparam int MAX_TESTS  = 64;
  localparam int CLK_PERIOD = 8;

  logic                                        clk;
  logic                                        arst_n;
  logic                   [`MCAST_NUM_REQ-1:0] req_valid;
  logic                   [`MCAST_NUM_REQ-1:0] req_ready;
  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0] req_addr;
  mcast_types_pkg::addr_t [`MCAST_NUM_REQ-1:0] req_mask;
  mcast_types_pkg::data_t [`MCAST_NUM_REQ-1:0] req_data;
  logic                   [`MCAST_NUM_REQ-1:0] resp_valid;
  logic                   [`MCAST_NUM_REQ-1:0] resp_err;
  logic                   [`MCAST_NUM_TGT-1:0] tgt_valid;
  logic                   [`MCAST_NUM_TGT-1:0] tgt_ready;
  mcast_types_pkg::addr_t [`MCAST_NUM_TGT-1:0] tgt_addr;
  mcast_types_pkg::data_t [`MCAST_NUM_TGT-1:0] tgt_data;

  // Four words per test: requester, address, mask, data
  logic [31:0] vec [0:4*MAX_TESTS-1];
  int          num_tests;
  integer      seed;
  int          cycle;
  logic [31:0] rnd;
  int          data_errs;
  int          resp_errs;
  int          proto_errs;
  int          pending;
  int          stalls;

  mcast_xbar_top DUT (
    .clk_i            ( clk        ),
    .arst_n_i         ( arst_n     ),
    .req_valid_i      ( req_valid  ),
    .req_ready_o      ( req_ready  ),
    .req_addr_i       ( req_addr   ),
    .req_mask_i       ( req_mask   ),
    .req_data_i       ( req_data   ),
    .req_resp_valid_o ( resp_valid ),
    .req_resp_err_o   ( resp_err   ),
    .tgt_valid_o      ( tgt_valid  ),
    .tgt_ready_i      ( tgt_ready  ),
    .tgt_addr_o       ( tgt_addr   ),
    .tgt_data_o       ( tgt_data   )
  );

  mcast_checker u_checker (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .req_valid_i  ( req_valid  ),
    .req_ready_i  ( req_ready  ),
    .req_addr_i   ( req_addr   ),
    .req_mask_i   ( req_mask   ),
    .req_data_i   ( req_data   ),
    .resp_valid_i ( resp_valid ),
    .resp_err_i   ( resp_err   ),
    .tgt_valid_i  ( tgt_valid  ),
    .tgt_ready_i  ( tgt_ready  ),
    .tgt_addr_i   ( tgt_addr   ),
    .tgt_data_i   ( tgt_data   ),
    .data_errs_o  ( data_errs  ),
    .resp_errs_o  ( resp_errs  ),
    .proto_errs_o ( proto_errs ),
    .pending_o    ( pending    ),
    .stalls_o     ( stalls     )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Offers this requester's lines in file order, each held until accepted
  task automatic drive_requester(input int r);
    for (int i = 0; i < num_tests; i++) begin
      if (vec[4*i] == r) begin
        @(negedge clk);
        req_valid[r] = 1'b1;
        req_addr[r]  = vec[4*i+1];
        req_mask[r]  = vec[4*i+2];
        req_data[r]  = vec[4*i+3];
        #2;
        while (!req_ready[r]) begin
          @(negedge clk);
          #2;
        end
      end
    end
    @(negedge clk);
    req_valid[r] = 1'b0;
  endtask

  // Random target readies, target 1 is held off from the start to back up the FIFO
  always @(negedge clk) begin
    if (!arst_n) begin
      tgt_ready = '0;
    end else begin
      rnd       = $random(seed);
      tgt_ready = rnd[3:0] | rnd[7:4];
      if (cycle < 60) begin
        tgt_ready[1] = 1'b0;
      end
      cycle++;
    end
  end

  initial begin
    @(posedge arst_n);
    repeat (200 * num_tests) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", 200 * num_tests);
    $display("Something failed");
    $finish;
  end

  initial begin
    req_valid = '0;
    req_addr  = '0;
    req_mask  = '0;
    req_data  = '0;
    tgt_ready = '0;
    arst_n    = 1'b0;
    cycle     = 0;
    seed      = 32'h41cfc21b;
    for (int i = 0; i < 4*MAX_TESTS; i++) begin
      vec[i] = 32'hFFFF_FFFF;
    end
    $readmemh("verif/mcast_tests.txt", vec);
    num_tests = 0;
    while (num_tests < MAX_TESTS && vec[4*num_tests] != 32'hFFFF_FFFF) begin
      num_tests++;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (3) @(posedge clk);
    fork
      drive_requester(0);
      drive_requester(1);
    join
    wait (pending == 0);
    repeat (10) @(negedge clk);
    $display("Checks done: %0d data, %0d resp, %0d protocol errors, %0d left, %0d full stalls",
             data_errs, resp_errs, proto_errs, pending, stalls);
    if (stalls == 0) begin
      $display("The FIFO never filled, so requester back-pressure was not exercised");
    end
    if (data_errs == 0 && resp_errs == 0 && proto_errs == 0 && pending == 0 &&
        stalls > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verif/mcast_tests.txt ====
// Columns in hex: requester, address, mask, data
// Mask bits 12 and 13 widen the target index
00000000 00000010 00000000 A0000001
00000001 00001020 00000000 A0000002
00000000 00002030 00000000 A0000003
00000001 00003040 00000000 A0000004
00000000 00000100 00001000 B0000001
00000001 00002200 00002000 B0000002
00000000 00001300 00003000 B0000003
00000001 00004000 00000000 C0000001
00000000 80000000 00003000 C0000002
00000000 00001004 00000000 D0000001
00000001 00001008 00000000 D0000002
00000000 00003010 00001000 D0000003
00000001 00000014 00003000 D0000004
00000000 00001018 00000000 D0000005
00000001 00002020 00000000 D0000006
00000000 00001024 00002000 D0000007
00000001 00003028 00000000 D0000008
00000000 00000030 00000000 D0000009
00000001 00001034 00000000 D000000A
00000000 00010000 00000000 D000000B

// ==== filelist.f ====
+incdir+common
common/mcast_types_pkg.sv
common/mcast_ctrl_pkg.sv
common/mcast_req_if.sv
ingress/mcast_ingress.sv
design/mcast_req_fifo.sv
fanout/mcast_fanout.sv
design/mcast_xbar_top.sv
verif/mcast_checker.sv
verif/tb_mcast_xbar.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mcast_xbar
BUILD     ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
